// File: src/sram_ctrl_pkg.sv
// shared widths, types and halfword cycle timing for the async SRAM controller
package sram_ctrl_pkg;

	localparam int word_w = 32; // CPU and display word
	localparam int half_w = 16; // SRAM data bus width
	localparam int sram_addr_w = 23; // halfword address at the chip

	typedef logic [word_w-1:0] word_t; // one full 32-bit word
	typedef logic [half_w-1:0] half_t; // one SRAM halfword
	typedef logic [sram_addr_w-1:0] sram_addr_t; // word address plus halfword select

	localparam int rd_phase_cycles = 2; // each read half holds the address for two cycles
	localparam int wr_phase_cycles = 3; // each write half is setup, pulse, hold

	// the phase counter has to reach the longer of the two phase lengths
	localparam int phase_w = $clog2(wr_phase_cycles);

	typedef logic [phase_w-1:0] phase_t; // position inside one halfword phase

	localparam phase_t rd_phase_last = phase_t'(rd_phase_cycles - 1); // last read cycle
	localparam phase_t wr_phase_last = phase_t'(wr_phase_cycles - 1); // last write cycle
	localparam phase_t wr_pulse_cycle = phase_t'(wr_phase_cycles / 2); // we_n low here only

	// halfword select bit on sram_addr, high half goes out first
	localparam logic half_hi = 1'b0;
	localparam logic half_lo = 1'b1;

endpackage

// File: src/sram_word_ctrl.sv
// word controller that runs one 32-bit access as two halfword cycles on the async SRAM
module sram_word_ctrl import sram_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start, // one-cycle request, ignored while busy
	input logic write, // 1 for a full word write, 0 for a read
	input word_t addr, // byte address, held by the arbiter until done
	input word_t wdata, // write word, also held until done
	output word_t rdata, // assembled read word, valid in the done cycle
	output logic done, // one-cycle pulse at the end of the second half
	output sram_addr_t sram_addr,
	output logic sram_ce_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	inout wire half_t sram_data
);

	logic busy; // an access is on the pins
	logic half_sel; // 0 while the high half runs, 1 for the low half
	phase_t phase_cnt; // cycle position inside the current half
	phase_t phase_last; // last cycle of a half for this access type
	logic phase_end; // this cycle closes the current half
	logic drive_data; // the controller owns the data bus this cycle

	// a write half needs the extra hold cycle after the pulse
	assign phase_last = write ? wr_phase_last : rd_phase_last;
	assign phase_end = busy && (phase_cnt == phase_last);

	// upper word address bits with the halfword select as the lowest chip bit
	assign sram_addr = {addr[sram_addr_w:2], half_sel};

	assign sram_ce_n = !busy; // chip selected only while an access runs
	assign sram_oe_n = !(busy && !write); // outputs of the chip on for reads only
	// the pulse sits in the middle so address and data settle before and after it
	assign sram_we_n = !(busy && write && (phase_cnt == wr_pulse_cycle));

	assign drive_data = busy && write;
	assign sram_data = drive_data ?
		((half_sel == half_hi) ? wdata[word_w-1:half_w] : wdata[half_w-1:0]) :
		{half_w{1'bz}}; // released whenever no write half is running

	// sequencing of the two halves
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			half_sel <= half_hi;
			phase_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0; // pulse lasts one cycle unless set below
			if (!busy) begin
				if (start) begin
					busy <= 1'b1; // first half begins in the next cycle
					half_sel <= half_hi; // high half always goes first
					phase_cnt <= '0;
				end
			end else if (phase_end) begin
				phase_cnt <= '0; // next half starts at its first cycle
				if (half_sel == half_lo) begin
					busy <= 1'b0; // both halves are finished
					half_sel <= half_hi;
					done <= 1'b1;
				end else begin
					half_sel <= half_lo; // move on to the low half
				end
			end else begin
				phase_cnt <= phase_cnt + phase_t'(1);
			end
		end
	end

	// read data is taken at the last cycle of each half, when the chip output has settled
	always_ff @(posedge clk) begin
		if (phase_end && !write) begin
			if (half_sel == half_hi) begin
				rdata[word_w-1:half_w] <= sram_data; // high half lands first
			end else begin
				rdata[half_w-1:0] <= sram_data; // low half completes the word with done
			end
		end
	end

endmodule

// File: src/sram_port_arbiter.sv
// port arbiter that serializes instruction, data and display accesses onto one word controller
module sram_port_arbiter import sram_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_en, // fetch request level
	input word_t instr_addr,
	input logic data_en, // data request level
	input word_t data_addr,
	input logic data_write, // data request is a write
	input word_t data_wdata,
	input logic vga_read, // display read request level
	input word_t vga_addr,
	output word_t instr_rdata, // last fetched word
	output word_t data_rdata, // last data read word
	output logic cpu_stall,
	output word_t vga_rdata, // last display word
	output logic vga_rdy, // one-cycle pulse when vga_rdata is fresh
	output logic start, // one-cycle start toward the word controller
	output word_t acc_addr,
	output logic acc_write,
	output word_t acc_wdata,
	input word_t acc_rdata,
	input logic acc_done
);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_data,
		st_complete,
		st_display,
		st_disp_wait
	} arb_state_t;

	arb_state_t state; // current owner of the word controller
	logic pend_data; // a data access follows the running fetch
	logic cpu_req; // any CPU request level is up

	assign cpu_req = instr_en || data_en;

	// the CPU waits whenever a request is up and not yet finished
	// during the display states it has to wait too, so its request is not taken as done
	always_comb begin
		case (state)
			st_fetch, st_data: cpu_stall = 1'b1; // CPU access running
			st_idle, st_display, st_disp_wait: cpu_stall = cpu_req; // request seen but not served
			default: cpu_stall = 1'b0; // complete cycle releases the CPU
		endcase
	end

	// address and write data come straight from the held request of the active port
	always_comb begin
		case (state)
			st_data: acc_addr = data_addr;
			st_display: acc_addr = vga_addr;
			default: acc_addr = instr_addr; // fetch, and a harmless value elsewhere
		endcase
	end

	assign acc_write = (state == st_data) && data_write; // fetch and display only read
	assign acc_wdata = data_wdata;

	// state machine and start pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			pend_data <= 1'b0;
			start <= 1'b0;
			vga_rdy <= 1'b0;
		end else begin
			start <= 1'b0; // start is a single-cycle pulse
			vga_rdy <= 1'b0;
			case (state)
				st_idle: begin
					if (instr_en) begin
						state <= st_fetch; // the fetch goes first when both come together
						pend_data <= data_en;
						start <= 1'b1;
					end else if (data_en) begin
						state <= st_data;
						pend_data <= 1'b0;
						start <= 1'b1;
					end else if (vga_read) begin
						state <= st_display; // display only gets a free controller
						start <= 1'b1;
					end
				end
				st_fetch: begin
					if (acc_done) begin
						if (pend_data) begin
							state <= st_data; // data access runs right behind the fetch
							pend_data <= 1'b0;
							start <= 1'b1;
						end else begin
							state <= st_complete;
						end
					end
				end
				st_data: begin
					if (acc_done) begin
						state <= st_complete;
					end
				end
				st_complete: begin
					state <= st_idle; // request lines are not looked at in this cycle
				end
				st_display: begin
					if (acc_done) begin
						state <= st_disp_wait;
						vga_rdy <= 1'b1; // word is on vga_rdata from the next cycle
					end
				end
				st_disp_wait: begin
					if (!vga_read) begin
						state <= st_idle; // the display has withdrawn its request
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// result capture on each done, a data write leaves data_rdata alone
	always_ff @(posedge clk) begin
		if (acc_done) begin
			if (state == st_fetch) begin
				instr_rdata <= acc_rdata;
			end
			if ((state == st_data) && !data_write) begin
				data_rdata <= acc_rdata;
			end
			if (state == st_display) begin
				vga_rdata <= acc_rdata;
			end
		end
	end

endmodule

// File: src/sram_subsystem_top.sv
// memory subsystem top joining the port arbiter to the word controller and the SRAM pins
module sram_subsystem_top import sram_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_en,
	input word_t instr_addr,
	input logic data_en,
	input word_t data_addr,
	input logic data_write,
	input word_t data_wdata,
	output word_t instr_rdata,
	output word_t data_rdata,
	output logic cpu_stall,
	input logic vga_read,
	input word_t vga_addr,
	output word_t vga_rdata,
	output logic vga_rdy,
	output sram_addr_t sram_addr,
	output logic sram_ce_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	inout wire half_t sram_data
);

	logic start; // arbiter asks the controller for one word access
	logic acc_write;
	word_t acc_addr;
	word_t acc_wdata;
	word_t acc_rdata; // word back from the controller
	logic acc_done;

	sram_port_arbiter u_arbiter (
		.clk(clk), .rst(rst),
		.instr_en(instr_en), .instr_addr(instr_addr),
		.data_en(data_en), .data_addr(data_addr),
		.data_write(data_write), .data_wdata(data_wdata),
		.vga_read(vga_read), .vga_addr(vga_addr),
		.instr_rdata(instr_rdata), .data_rdata(data_rdata), .cpu_stall(cpu_stall),
		.vga_rdata(vga_rdata), .vga_rdy(vga_rdy),
		.start(start), .acc_addr(acc_addr), .acc_write(acc_write), .acc_wdata(acc_wdata),
		.acc_rdata(acc_rdata), .acc_done(acc_done)
	);

	sram_word_ctrl u_word_ctrl (
		.clk(clk), .rst(rst),
		.start(start), .write(acc_write), .addr(acc_addr), .wdata(acc_wdata),
		.rdata(acc_rdata), .done(acc_done),
		.sram_addr(sram_addr), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n), .sram_data(sram_data)
	);

endmodule

// File: bench/async_sram_model.sv
// behavioral 16-bit asynchronous SRAM with a tristate data bus for simulation only
module async_sram_model import sram_ctrl_pkg::*; #(
	parameter int addr_bits = 10 // halfword address bits that the model decodes
) (
	input sram_addr_t sram_addr,
	input logic sram_ce_n,
	input logic sram_oe_n,
	input logic sram_we_n,
	inout wire half_t sram_data
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 1 << addr_bits; // halfwords held by the model

	half_t mem [0:depth-1];
	logic [addr_bits-1:0] index; // upper chip address bits alias onto the model
	logic read_en; // chip drives the bus only in this case

	assign index = sram_addr[addr_bits-1:0];
	assign read_en = !sram_ce_n && !sram_oe_n && sram_we_n;
	assign sram_data = read_en ? mem[index] : {half_w{1'bz}}; // released otherwise

	// the array powers up as zero so unwritten words read back as zero
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	// data is taken at the end of the write pulse, like a real async part
	always @(posedge sram_we_n) begin
		if (!sram_ce_n) begin
			mem[index] = sram_data;
		end
	end

endmodule

// File: bench/tb_sram_subsystem.sv
// testbench for the SRAM subsystem with directed tests checked against a shadow memory
module tb_sram_subsystem import sram_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int model_bits = 10; // model depth in halfword address bits
	localparam int reset_cycles = 8;
	localparam int wait_limit = 40; // longest single wait for stall or vga_rdy
	localparam int num_random = 40;
	localparam int op_cycles = 20; // worst request is a fetch plus a write
	localparam int num_ops = num_random + 20; // directed tests add about twenty requests
	localparam int watchdog_cycles = 2 * (reset_cycles + num_ops * op_cycles);

	logic clk;
	logic rst;
	logic instr_en;
	word_t instr_addr;
	logic data_en;
	word_t data_addr;
	logic data_write;
	word_t data_wdata;
	logic vga_read;
	word_t vga_addr;
	word_t instr_rdata;
	word_t data_rdata;
	word_t vga_rdata;
	logic cpu_stall;
	logic vga_rdy;
	sram_addr_t sram_addr;
	logic sram_ce_n;
	logic sram_oe_n;
	logic sram_we_n;
	wire half_t sram_data; // shared by the controller and the chip model

	word_t shadow [0:(1 << (model_bits - 1)) - 1]; // one word per two model halfwords
	word_t last_instr; // predicted values that the CPU result registers hold
	word_t last_data;
	string test_name;
	integer seed;

	sram_subsystem_top uut (.*);

	async_sram_model #(.addr_bits(model_bits)) u_sram (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles with tests still running",
			watchdog_cycles));
	end

	task automatic check_word(input string what, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail %s %s: expected %h actual %h", test_name, what,
				expected, actual));
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail %s %s: expected %b actual %b", test_name, what,
				expected, actual));
		end
	endtask

	function automatic int shadow_index(input word_t addr);
		return int'(addr[model_bits:2]); // same word bits the model decodes
	endfunction

	// returns at the falling edge inside the complete cycle
	task automatic wait_cpu_done();
		int n;
		n = 0;
		@(negedge clk);
		while (cpu_stall) begin
			check_flag("vga_rdy while stalled", 1'b0, vga_rdy); // display waits its turn
			n++;
			if (n > wait_limit) begin
				abort_run("cpu_stall never went low, the CPU access did not complete");
			end
			@(negedge clk);
		end
	endtask

	task automatic cpu_request(input logic fetch, input word_t iaddr, input logic data,
		input logic wr, input word_t daddr, input word_t wdata);
		word_t exp_instr;
		word_t exp_data;
		exp_instr = shadow[shadow_index(iaddr)]; // fetch runs first so it sees the old word
		exp_data = shadow[shadow_index(daddr)];
		@(posedge clk);
		instr_en <= fetch;
		instr_addr <= iaddr;
		data_en <= data;
		data_write <= wr;
		data_addr <= daddr;
		data_wdata <= wdata;
		wait_cpu_done();
		if (fetch) begin
			last_instr = exp_instr;
		end
		if (data && !wr) begin
			last_data = exp_data;
		end
		if (data && wr) begin
			shadow[shadow_index(daddr)] = wdata;
		end
		check_word("instr_rdata", last_instr, instr_rdata); // a write leaves data_rdata alone
		check_word("data_rdata", last_data, data_rdata);
		@(posedge clk);
		instr_en <= 1'b0; // dropped in the cycle after complete
		data_en <= 1'b0;
	endtask

	task automatic display_read(input word_t addr);
		word_t expected;
		int n;
		expected = shadow[shadow_index(addr)];
		if (!vga_read) begin
			@(posedge clk);
			vga_read <= 1'b1;
			vga_addr <= addr;
		end
		n = 0;
		@(negedge clk);
		while (!vga_rdy) begin
			n++;
			if (n > wait_limit) begin
				abort_run("vga_rdy never pulsed for the display read");
			end
			@(negedge clk);
		end
		check_word("vga_rdata", expected, vga_rdata);
		@(posedge clk);
		vga_read <= 1'b0;
		@(negedge clk);
		check_flag("vga_rdy second cycle", 1'b0, vga_rdy); // pulse is one cycle wide
	endtask

	task automatic reset_state();
		test_name = "reset";
		check_flag("cpu_stall", 1'b0, cpu_stall);
		check_flag("vga_rdy", 1'b0, vga_rdy);
		check_flag("sram_we_n", 1'b1, sram_we_n);
		check_flag("sram_ce_n", 1'b1, sram_ce_n);
		check_flag("sram_oe_n", 1'b1, sram_oe_n);
		// never written, so both the fetch and the data read return zero
		cpu_request(1'b1, 32'h0000_0120, 1'b1, 1'b0, 32'h0000_0124, '0);
	endtask

	task automatic write_then_read();
		word_t addrs [4] = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0108, 32'h0000_07fc};
		word_t words [4] = '{32'h1234_5678, 32'h8765_4321, 32'hdead_beef, 32'h0f0f_f0f0};
		test_name = "write_read";
		foreach (addrs[i]) begin
			cpu_request(1'b0, '0, 1'b1, 1'b1, addrs[i], words[i]);
		end
		foreach (addrs[i]) begin
			cpu_request(1'b0, '0, 1'b1, 1'b0, addrs[i], '0); // swapped halves would show here
		end
	endtask

	task automatic fetch_with_data();
		test_name = "fetch_data";
		cpu_request(1'b1, 32'h0000_0004, 1'b1, 1'b1, 32'h0000_0200, 32'ha5a5_5a5a);
		cpu_request(1'b0, '0, 1'b1, 1'b0, 32'h0000_0200, '0);
		cpu_request(1'b1, 32'h0000_0200, 1'b1, 1'b1, 32'h0000_0200, 32'h3c3c_c3c3); // old word
		cpu_request(1'b1, 32'h0000_0200, 1'b1, 1'b0, 32'h0000_0108, '0); // both results at once
	endtask

	task automatic idle_display();
		test_name = "display";
		display_read(32'h0000_0108);
		display_read(32'h0000_0388); // unwritten, so zero
		check_word("instr_rdata held", last_instr, instr_rdata);
		check_word("data_rdata held", last_data, data_rdata);
	endtask

	task automatic stalled_display();
		test_name = "display_busy";
		@(posedge clk);
		data_en <= 1'b1;
		data_write <= 1'b1;
		data_addr <= 32'h0000_0340;
		data_wdata <= 32'hcafe_f00d;
		repeat (2) @(posedge clk);
		vga_read <= 1'b1; // raised while the write is stalling the CPU
		vga_addr <= 32'h0000_0340;
		wait_cpu_done();
		shadow[shadow_index(32'h0000_0340)] = 32'hcafe_f00d;
		@(posedge clk);
		data_en <= 1'b0;
		display_read(32'h0000_0340); // served after the write, so it sees the new word
	endtask

	task automatic random_mix();
		word_t r;
		word_t addr;
		test_name = "random";
		repeat (num_random) begin
			r = $random(seed);
			addr = $random(seed) & 32'h0000_0ffc; // bit 11 aliases in the model and shadow alike
			case (r[1:0])
				2'd0: cpu_request(1'b1, addr, 1'b0, 1'b0, '0, '0);
				2'd1: cpu_request(1'b0, '0, 1'b1, 1'b0, addr, '0);
				2'd2: cpu_request(1'b1, addr ^ 32'h40, 1'b1, 1'b1, addr, $random(seed));
				default: cpu_request(1'b0, '0, 1'b1, 1'b1, addr, $random(seed));
			endcase
		end
	endtask

	initial begin
		seed = 32'hf28e;
		foreach (shadow[i]) begin
			shadow[i] = '0; // the model powers up as zero
		end
		last_instr = '0;
		last_data = '0;
		rst <= 1'b1;
		instr_en <= 1'b0;
		instr_addr <= '0;
		data_en <= 1'b0;
		data_addr <= '0;
		data_write <= 1'b0;
		data_wdata <= '0;
		vga_read <= 1'b0;
		vga_addr <= '0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		reset_state();
		write_then_read();
		fetch_with_data();
		idle_display();
		stalled_display();
		random_mix();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: build.f
src/sram_ctrl_pkg.sv
src/sram_word_ctrl.sv
src/sram_port_arbiter.sv
src/sram_subsystem_top.sv
bench/async_sram_model.sv
bench/tb_sram_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the SRAM subsystem testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -f build.f --top-module tb_sram_subsystem -o tb_sram_subsystem
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sram_subsystem > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
